//--- common/cmd_mem_iface.sv
//--------------------------------------------------------------------------
// Command fetch path. Banks show the word addressed one clock earlier.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface cmd_mem_iface;

    logic [dsp_pkg::cmd_addr_width-1:0]                      instr_ptr;
    logic [dsp_pkg::cmd_banks-1:0][dsp_pkg::bank_width-1:0] banks;  // Bank 0 is LSBs.

    modport mem (
        input  instr_ptr,
        output banks
    );

    modport seq (
        output instr_ptr,
        input  banks
    );

endinterface

//--- common/dsp_pkg.sv
//--------------------------------------------------------------------------
// Shared widths, word address map and command encodings for one channel.
// Commands are 128 bits over four 32-bit banks, bank 0 holding bits 31..0.
//--------------------------------------------------------------------------
package dsp_pkg;

    localparam int cmd_addr_width = 8;
    localparam int cmd_banks      = 4;
    localparam int cmd_bank_width = 2;
    localparam int bank_width     = 32;
    localparam int cmd_width      = cmd_banks * bank_width;
    localparam int env_addr_width = 12;
    localparam int sample_width   = 16;
    localparam int phase_width    = 16;
    localparam int timer_width    = 32;
    localparam int loop_width     = 16;
    localparam int paddr_width    = 15;
    localparam int waddr_width    = paddr_width - 2; // Word address is paddr[14:2].

    // Word address fields.
    localparam int wave_sel_bit = 12;                // 0 selects command, 1 selects wave.
    localparam int resv_msb     = 11;
    localparam int resv_lsb     = 10;                // Must be zero on command writes.
    localparam int bank_msb     = 9;
    localparam int bank_lsb     = 8;

    // Sequencer states.
    localparam int          seq_state_width = 3;
    localparam logic [2:0]  st_idle         = 3'd0;
    localparam logic [2:0]  st_fetch        = 3'd1;
    localparam logic [2:0]  st_wait         = 3'd2;
    localparam logic [2:0]  st_issue        = 3'd3;
    localparam logic [2:0]  st_halt         = 3'd4;

    localparam int pulse_pad_width =
        cmd_width - 2 - timer_width - 2 * phase_width - 2 * env_addr_width;
    localparam int ctrl_pad_width =
        cmd_width - 2 - cmd_addr_width - loop_width - timer_width;

    // Opcode 0 is not listed and decodes as done.
    typedef enum logic [1:0] {
        op_pulse = 2'd1,
        op_ctrl  = 2'd2,
        op_done  = 2'd3
    } opcode_e;

    typedef struct packed {
        logic [pulse_pad_width-1:0] pad;
        logic [env_addr_width-1:0]  env_len;     // Zero gives one sample.
        logic [env_addr_width-1:0]  env_addr;
        logic [phase_width-1:0]     phase;
        logic [phase_width-1:0]     freq;        // Phase step per sample.
        logic [timer_width-1:0]     start_time;
        opcode_e                    opcode;
    } pulse_cmd_t;

    typedef struct packed {
        logic [ctrl_pad_width-1:0]  pad;
        logic [timer_width-1:0]     timer_reload;
        logic [loop_width-1:0]      loop_count;
        logic [cmd_addr_width-1:0]  target;
        opcode_e                    opcode;
    } ctrl_cmd_t;

    typedef union packed {
        pulse_cmd_t pulse;
        ctrl_cmd_t  ctrl;
    } command_u;

    typedef struct packed {
        logic [phase_width-1:0]    freq;
        logic [phase_width-1:0]    phase;
        logic [env_addr_width-1:0] env_addr;
        logic [env_addr_width-1:0] env_len;
    } pulse_t;

endpackage

//--- common/pulse_iface.sv
//--------------------------------------------------------------------------
// Pulse hand-off with no back-pressure. A strobe while active replaces the
// running pulse and raises collision for one cycle.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface pulse_iface;

    logic             cstrobe;   // One cycle, qualifies pulse.
    dsp_pkg::pulse_t  pulse;
    logic             active;
    logic             collision;

    modport src (
        output cstrobe,
        output pulse,
        input  active,
        input  collision
    );

    modport sink (
        input  cstrobe,
        input  pulse,
        output active,
        output collision
    );

endinterface

//--- dsp_unit.f
common/dsp_pkg.sv
common/cmd_mem_iface.sv
common/pulse_iface.sv
hw/apb_write_decoder.sv
hw/cmd_buffer.sv
sequencer/pulse_sequencer.sv
element/pulse_element.sv
hw/dsp_unit.sv
tb/tb_dsp_unit.sv

//--- element/pulse_element.sv
//--------------------------------------------------------------------------
// Envelope playback rotated by quarter turns from the top two phase bits.
// First sample two cycles after cstrobe, envelope address wraps at 12 bits.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pulse_element (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 env_we,
    input  logic [dsp_pkg::env_addr_width-1:0]   env_addr,
    input  logic [dsp_pkg::sample_width-1:0]     env_data,
    pulse_iface.sink                             pulse_if,
    output logic signed [dsp_pkg::sample_width-1:0] dac_i,
    output logic signed [dsp_pkg::sample_width-1:0] dac_q,
    output logic                                 dac_valid
);

    logic [dsp_pkg::sample_width-1:0]   env_mem [2**dsp_pkg::env_addr_width];
    logic                               running;
    logic [dsp_pkg::env_addr_width-1:0] rd_addr;
    logic [dsp_pkg::env_addr_width-1:0] remaining;
    logic [dsp_pkg::phase_width-1:0]    phase_acc;
    logic [dsp_pkg::phase_width-1:0]    freq_q;
    logic signed [dsp_pkg::sample_width-1:0] env_q;
    logic [1:0]                         quad_q;
    logic                               valid_q;

    assign pulse_if.active = running | valid_q;

    always_ff @(posedge clk) begin
        if (env_we) begin
            env_mem[env_addr] <= env_data;
        end
        env_q <= env_mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running            <= 1'b0;
            valid_q            <= 1'b0;
            pulse_if.collision <= 1'b0;
        end else begin
            valid_q            <= running;            // Aligns with RAM output.
            pulse_if.collision <= pulse_if.cstrobe & pulse_if.active;
            if (pulse_if.cstrobe) begin
                running <= 1'b1;
            end else if (running && remaining == '0) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        quad_q <= phase_acc[dsp_pkg::phase_width-1 -: 2];
        if (pulse_if.cstrobe) begin
            rd_addr   <= pulse_if.pulse.env_addr;
            remaining <= pulse_if.pulse.env_len;
            phase_acc <= pulse_if.pulse.phase;
            freq_q    <= pulse_if.pulse.freq;
        end else if (running) begin
            rd_addr   <= rd_addr + 1'b1;              // Wraps at 4096.
            remaining <= remaining - 1'b1;
            phase_acc <= phase_acc + freq_q;
        end
    end

    assign dac_valid = valid_q;

    always_comb begin
        dac_i = '0;
        dac_q = '0;
        if (valid_q) begin
            case (quad_q)
                2'd0: dac_i = env_q;
                2'd1: dac_q = env_q;
                2'd2: dac_i = -env_q;                 // Full scale negative wraps.
                default: dac_q = -env_q;
            endcase
        end
    end

endmodule

//--- hw/apb_write_decoder.sv
//--------------------------------------------------------------------------
// Write-only APB slave with zero wait states. Reads return 0 with an error.
// Each legal write reaches the memories one cycle after its access phase.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module apb_write_decoder (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [dsp_pkg::paddr_width-1:0]      paddr,
    input  logic [dsp_pkg::bank_width-1:0]       pwdata,
    output logic [dsp_pkg::bank_width-1:0]       prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 cmd_we,
    output logic [dsp_pkg::cmd_bank_width-1:0]   cmd_bank,
    output logic [dsp_pkg::cmd_addr_width-1:0]   cmd_addr,
    output logic                                 env_we,
    output logic [dsp_pkg::env_addr_width-1:0]   env_addr,
    output logic [dsp_pkg::sample_width-1:0]     env_data,
    output logic [dsp_pkg::bank_width-1:0]       wdata
);

    logic [dsp_pkg::waddr_width-1:0] waddr;
    logic                            access;
    logic                            is_wave;
    logic                            resv_err;

    assign waddr    = paddr[dsp_pkg::paddr_width-1:2];
    assign access   = psel & penable;                // Access phase.
    assign is_wave  = waddr[dsp_pkg::wave_sel_bit];
    assign resv_err = ~is_wave & (|waddr[dsp_pkg::resv_msb:dsp_pkg::resv_lsb]);

    assign prdata  = '0;
    assign pready  = 1'b1;
    assign pslverr = access & (~pwrite | resv_err);

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_we <= 1'b0;
            env_we <= 1'b0;
        end else begin
            cmd_we <= access & pwrite & ~is_wave & ~resv_err;
            env_we <= access & pwrite & is_wave;
        end
    end

    always_ff @(posedge clk) begin
        if (access & pwrite) begin
            cmd_bank <= waddr[dsp_pkg::bank_msb:dsp_pkg::bank_lsb];
            cmd_addr <= waddr[dsp_pkg::cmd_addr_width-1:0];
            env_addr <= waddr[dsp_pkg::env_addr_width-1:0];
            env_data <= pwdata[dsp_pkg::sample_width-1:0];
            wdata    <= pwdata;
        end
    end

endmodule

//--- hw/cmd_buffer.sv
//--------------------------------------------------------------------------
// Four 256 x 32 RAM banks read together as one 128-bit command.
// Read latency is one clock and contents are not initialised.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cmd_buffer (
    input  logic                                clk,
    input  logic                                we,
    input  logic [dsp_pkg::cmd_bank_width-1:0]  bank,
    input  logic [dsp_pkg::cmd_addr_width-1:0]  addr,
    input  logic [dsp_pkg::bank_width-1:0]      wdata,
    cmd_mem_iface.mem                           memif
);

    for (genvar b = 0; b < dsp_pkg::cmd_banks; b++) begin : g_bank
        logic [dsp_pkg::bank_width-1:0] mem [2**dsp_pkg::cmd_addr_width];

        always_ff @(posedge clk) begin
            if (we && bank == dsp_pkg::cmd_bank_width'(b)) begin
                mem[addr] <= wdata;
            end
            memif.banks[b] <= mem[memif.instr_ptr];  // Registered read.
        end
    end

endmodule

//--- hw/dsp_unit.sv
//--------------------------------------------------------------------------
// One pulse channel with an APB write port, a single start input and a
// done output. One I/Q sample per clock on the DAC pins.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_unit (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [dsp_pkg::paddr_width-1:0]         paddr,
    input  logic [dsp_pkg::bank_width-1:0]          pwdata,
    input  logic                                    start,
    output logic [dsp_pkg::bank_width-1:0]          prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    done,
    output logic signed [dsp_pkg::sample_width-1:0] dac_i,
    output logic signed [dsp_pkg::sample_width-1:0] dac_q,
    output logic                                    dac_valid
);

    logic                               cmd_we;
    logic [dsp_pkg::cmd_bank_width-1:0] cmd_bank;
    logic [dsp_pkg::cmd_addr_width-1:0] cmd_addr;
    logic [dsp_pkg::bank_width-1:0]     wdata;
    logic                               env_we;
    logic [dsp_pkg::env_addr_width-1:0] env_addr;
    logic [dsp_pkg::sample_width-1:0]   env_data;

    cmd_mem_iface memif ();
    pulse_iface   pulse_bus ();

    apb_write_decoder apb_dec (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cmd_we   (cmd_we),
        .cmd_bank (cmd_bank),
        .cmd_addr (cmd_addr),
        .env_we   (env_we),
        .env_addr (env_addr),
        .env_data (env_data),
        .wdata    (wdata)
    );

    cmd_buffer cmd_buf (
        .clk   (clk),
        .we    (cmd_we),
        .bank  (cmd_bank),
        .addr  (cmd_addr),
        .wdata (wdata),
        .memif (memif.mem)
    );

    pulse_sequencer seq (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .memif    (memif.seq),
        .pulse_if (pulse_bus.src),
        .done     (done)
    );

    pulse_element elem (
        .clk       (clk),
        .reset     (reset),
        .env_we    (env_we),
        .env_addr  (env_addr),
        .env_data  (env_data),
        .pulse_if  (pulse_bus.sink),
        .dac_i     (dac_i),
        .dac_q     (dac_q),
        .dac_valid (dac_valid)
    );

endmodule

//--- sequencer/pulse_sequencer.sv
//--------------------------------------------------------------------------
// Runs the command program against a free-running 32-bit timer. One loop
// counter only, so ctrl loops do not nest. Events need 3 cycles of spacing.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pulse_sequencer (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    cmd_mem_iface.seq   memif,
    pulse_iface.src     pulse_if,
    output logic        done
);

    logic [dsp_pkg::seq_state_width-1:0] state;
    logic [dsp_pkg::timer_width-1:0]     timer;
    logic [dsp_pkg::cmd_addr_width-1:0]  ip;
    logic [dsp_pkg::loop_width-1:0]      loop_cnt;
    dsp_pkg::command_u                   cmd;
    logic                                time_hit;

    assign cmd             = memif.banks;
    assign memif.instr_ptr = ip;

    // Fires one cycle ahead so the strobe lands on timer == start_time.
    assign time_hit = (timer + 1'b1) >= cmd.pulse.start_time;

    assign pulse_if.cstrobe = (state == dsp_pkg::st_issue)
                            && (cmd.pulse.opcode == dsp_pkg::op_pulse);
    assign pulse_if.pulse   = '{freq:     cmd.pulse.freq,
                                phase:    cmd.pulse.phase,
                                env_addr: cmd.pulse.env_addr,
                                env_len:  cmd.pulse.env_len};

    // Held once the last pulse has drained out of the element.
    assign done = (state == dsp_pkg::st_halt) & ~pulse_if.active;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= dsp_pkg::st_idle;
            timer    <= '0;
            ip       <= '0;
            loop_cnt <= '0;
        end else begin
            timer <= timer + 1'b1;
            case (state)
                dsp_pkg::st_idle, dsp_pkg::st_halt: begin
                    if (start) begin
                        timer    <= '0;
                        ip       <= '0;
                        loop_cnt <= '0;
                        state    <= dsp_pkg::st_fetch;
                    end
                end
                dsp_pkg::st_fetch: state <= dsp_pkg::st_wait;  // RAM read in flight.
                dsp_pkg::st_wait: begin
                    if (cmd.pulse.opcode != dsp_pkg::op_pulse || time_hit) begin
                        state <= dsp_pkg::st_issue;
                    end
                end
                dsp_pkg::st_issue: begin
                    state <= dsp_pkg::st_fetch;
                    case (cmd.pulse.opcode)
                        dsp_pkg::op_pulse: ip <= ip + 1'b1;
                        dsp_pkg::op_ctrl: begin
                            if (loop_cnt < cmd.ctrl.loop_count) begin
                                loop_cnt <= loop_cnt + 1'b1;
                                ip       <= cmd.ctrl.target;
                                timer    <= cmd.ctrl.timer_reload;
                            end else begin
                                loop_cnt <= '0;
                                ip       <= ip + 1'b1;
                            end
                        end
                        default: state <= dsp_pkg::st_halt;  // op_done or zero.
                    endcase
                end
                default: state <= dsp_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- tb/tb_dsp_unit.sv
//--------------------------------------------------------------------------
// Loads a random envelope and a looped pulse program over APB, runs it twice
// and checks every DAC cycle against a cycle model. Needs a timing simulator.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dsp_unit;

    localparam int max_cycles = 1024;
    localparam int env_words  = 2 ** dsp_pkg::env_addr_width;

    logic                                    clk = 1'b0;
    logic                                    reset;
    logic                                    psel;
    logic                                    penable;
    logic                                    pwrite;
    logic [dsp_pkg::paddr_width-1:0]         paddr;
    logic [dsp_pkg::bank_width-1:0]          pwdata;
    logic                                    start;
    logic [dsp_pkg::bank_width-1:0]          prdata;
    logic                                    pready;
    logic                                    pslverr;
    logic                                    done;
    logic signed [dsp_pkg::sample_width-1:0] dac_i;
    logic signed [dsp_pkg::sample_width-1:0] dac_q;
    logic                                    dac_valid;

    logic [dsp_pkg::sample_width-1:0] env_model [env_words];
    dsp_pkg::command_u                prog [2**dsp_pkg::cmd_addr_width];
    bit                               exp_valid_arr [max_cycles];
    logic signed [15:0]               exp_i_arr [max_cycles];
    logic signed [15:0]               exp_q_arr [max_cycles];

    int unsigned        cyc = 0;
    int unsigned        run_base = 0;          // Cycle in which start is sampled.
    bit                 in_run = 1'b0;
    int unsigned        last_cycle = 0;
    int unsigned        watchdog_limit = 3 * (env_words + 32) + 2100;
    int                 mismatches = 0;
    int                 errors = 0;
    int unsigned        rel;
    logic               exp_v;
    logic signed [15:0] exp_i;
    logic signed [15:0] exp_q;
    logic               exp_slverr;

    dsp_unit UUT (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .start     (start),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .done      (done),
        .dac_i     (dac_i),
        .dac_q     (dac_q),
        .dac_valid (dac_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    assign rel   = cyc - run_base;
    assign exp_v = (in_run && rel < max_cycles) ? exp_valid_arr[rel] : 1'b0;
    assign exp_i = (in_run && rel < max_cycles) ? exp_i_arr[rel] : '0;
    assign exp_q = (in_run && rel < max_cycles) ? exp_q_arr[rel] : '0;

    // Reads fail, and so do command words with word bits 11..10 set.
    assign exp_slverr = psel && penable
                     && (!pwrite || (!paddr[14] && paddr[13:12] != 2'b00));

    a_apb_ready: assert property (@(posedge clk) disable iff (reset)
        pready && prdata == '0)
        else begin
            mismatches++;
            $display("mismatch at %0t: pready %0b prdata %h", $time,
                     $sampled(pready), $sampled(prdata));
        end

    a_apb_error: assert property (@(posedge clk) disable iff (reset)
        pslverr == exp_slverr)
        else begin
            mismatches++;
            $display("mismatch at %0t: pslverr %0b expected %0b", $time,
                     $sampled(pslverr), $sampled(exp_slverr));
        end

    a_dac_stream: assert property (@(posedge clk) disable iff (reset)
        dac_valid == exp_v && dac_i == exp_i && dac_q == exp_q)
        else begin
            mismatches++;
            $display("mismatch at %0t: cycle %0d got %0b/%0d/%0d expected %0b/%0d/%0d",
                     $time, $sampled(rel), $sampled(dac_valid), $sampled(dac_i),
                     $sampled(dac_q), $sampled(exp_v), $sampled(exp_i), $sampled(exp_q));
        end

    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        done && !start |=> done)
        else begin
            errors++;
            $display("done fell before the next start at %0t", $time);
        end

    a_done_clear: assert property (@(posedge clk) disable iff (reset)
        start |=> !done)
        else begin
            errors++;
            $display("done stayed high after start at %0t", $time);
        end

    a_done_early: assert property (@(posedge clk) disable iff (reset)
        in_run && rel >= 1 && rel <= last_cycle |-> !done)
        else begin
            errors++;
            $display("done rose before the last sample at %0t", $time);
        end

    function automatic logic [14:0] cmd_paddr(input logic [1:0] bank,
                                              input logic [7:0] addr,
                                              input logic [1:0] resv);
        return {1'b0, resv, bank, addr, 2'b00};
    endfunction

    function automatic logic [14:0] wave_paddr(input logic [11:0] addr);
        return {1'b1, addr, 2'b00};
    endfunction

    function automatic dsp_pkg::command_u pulse_cmd(input logic [31:0] start_time,
            input logic [15:0] freq, input logic [15:0] phase,
            input logic [11:0] env_addr, input logic [11:0] env_len);
        dsp_pkg::command_u c;
        c = '0;
        c.pulse.opcode     = dsp_pkg::op_pulse;
        c.pulse.start_time = start_time;
        c.pulse.freq       = freq;
        c.pulse.phase      = phase;
        c.pulse.env_addr   = env_addr;
        c.pulse.env_len    = env_len;
        return c;
    endfunction

    function automatic dsp_pkg::command_u ctrl_cmd(input logic [7:0] target,
            input logic [15:0] count, input logic [31:0] reload);
        dsp_pkg::command_u c;
        c = '0;
        c.ctrl.opcode       = dsp_pkg::op_ctrl;
        c.ctrl.target       = target;
        c.ctrl.loop_count   = count;
        c.ctrl.timer_reload = reload;
        return c;
    endfunction

    task automatic apb_access(input logic write, input logic [14:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;                           // Access phase with no wait states.
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [14:0] addr, input logic [31:0] data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [14:0] addr);
        apb_access(1'b0, addr, $urandom);          // Junk data must not land anywhere.
    endtask

    task automatic load_program(input int unsigned words);
        logic [dsp_pkg::cmd_width-1:0] w;
        int unsigned i;
        int unsigned b;
        for (i = 0; i < words; i++) begin
            w = prog[i];
            for (b = 0; b < dsp_pkg::cmd_banks; b++) begin
                apb_write(cmd_paddr(b[1:0], i[7:0], 2'b00), w[32*b +: 32]);
            end
        end
    endtask

    task automatic add_samples(input int unsigned first, input dsp_pkg::pulse_cmd_t p);
        int unsigned        k;
        int unsigned        c;
        logic [11:0]        addr;
        logic [15:0]        ph;
        logic signed [15:0] a;
        for (k = 0; k <= p.env_len; k++) begin
            c    = first + k;
            addr = p.env_addr + k[11:0];           // Wraps at 4096.
            ph   = p.phase + p.freq * k[15:0];
            a    = env_model[addr];
            if (c < max_cycles) begin
                exp_valid_arr[c] = 1'b1;
                case (ph[15:14])
                    2'd0: exp_i_arr[c] = a;
                    2'd1: exp_q_arr[c] = a;
                    2'd2: exp_i_arr[c] = -a;
                    default: exp_q_arr[c] = -a;
                endcase
            end
            last_cycle = c;
        end
    endtask

    // Cycle 0 samples start; the pointer first moves in cycle 1 with timer 0.
    task automatic build_expected();
        int unsigned       n;
        int unsigned       c;
        int unsigned       t;
        int unsigned       issue_t;
        logic [7:0]        ip;
        logic [15:0]       loop_cnt;
        bit                halted;
        dsp_pkg::command_u cmd;
        for (n = 0; n < max_cycles; n++) begin
            exp_valid_arr[n] = 1'b0;
            exp_i_arr[n]     = '0;
            exp_q_arr[n]     = '0;
        end
        last_cycle = 0;
        c          = 1;
        t          = 0;
        ip         = '0;
        loop_cnt   = '0;
        halted     = 1'b0;
        while (!halted) begin
            cmd = prog[ip];
            case (cmd.pulse.opcode)
                dsp_pkg::op_pulse: begin
                    issue_t = (cmd.pulse.start_time > t + 2) ? cmd.pulse.start_time : t + 2;
                    c = c + issue_t - t;           // Strobe cycle.
                    add_samples(c + 2, cmd.pulse);
                    c  = c + 1;
                    t  = issue_t + 1;
                    ip = ip + 8'd1;
                end
                dsp_pkg::op_ctrl: begin
                    if (loop_cnt < cmd.ctrl.loop_count) begin
                        loop_cnt = loop_cnt + 16'd1;
                        ip       = cmd.ctrl.target;
                        t        = cmd.ctrl.timer_reload;
                    end else begin
                        loop_cnt = '0;
                        ip       = ip + 8'd1;
                        t        = t + 3;
                    end
                    c = c + 3;
                end
                default: halted = 1'b1;
            endcase
        end
        watchdog_limit = watchdog_limit + last_cycle;
    endtask

    task automatic run_program();
        int unsigned n;
        build_expected();
        @(posedge clk);
        start    <= 1'b1;
        run_base <= cyc + 1;
        in_run   <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!done && n < last_cycle + 200) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            errors++;
            $display("done did not rise within %0d cycles of start", n);
        end
        in_run <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (done === 1'b0 && dac_valid === 1'b0)
            else begin
                errors++;
                $display("done or dac_valid not low after reset");
            end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("summary: %0d mismatches, %0d other errors", mismatches, errors);
        if (!timed_out && mismatches == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        wait (cyc > watchdog_limit);
        errors++;
        $display("timeout after %0d cycles, run stopped", cyc);
        finish_run(1'b1);
    end

    initial begin
        int unsigned a;
        logic [31:0] data;
        logic [15:0] freq0;
        void'($urandom(32'h4128));
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        start   = 1'b0;
        apply_reset();
        for (a = 0; a < env_words; a++) begin
            data = $urandom;
            if (a == 4093) begin
                data[15:0] = 16'h8000;             // Negation wraps here.
            end
            env_model[a] = data[15:0];
            apb_write(wave_paddr(a[11:0]), data);
        end
        freq0   = 16'($urandom);
        // Sample 3 reads address 4093 in quadrant 2.
        prog[0] = pulse_cmd(32'd20, freq0, 16'h8000 - 16'd3 * freq0, 12'd4090, 12'd15);
        prog[1] = pulse_cmd(32'd60, 16'($urandom), 16'($urandom), 12'($urandom), 12'd7);
        prog[2] = ctrl_cmd(8'd1, 16'd2, 32'd40);   // Body at 1 plays three times.
        prog[3] = pulse_cmd(32'd100, 16'($urandom), 16'($urandom), 12'($urandom), 12'd0);
        prog[4] = '0;
        prog[4].ctrl.opcode = dsp_pkg::op_done;
        load_program(5);
        apb_write(cmd_paddr(2'd0, 8'd0, 2'b01), '0);
        apb_read(wave_paddr(12'd4090));
        run_program();
        run_program();
        apply_reset();
        finish_run(1'b0);
    end

endmodule
